// File: mips_pkg.sv
`default_nettype none

package mips_pkg;

    localparam int word_w = 32;
    localparam int reg_addr_w = 5;
    localparam int pc_w = 32;
    localparam int dmem_depth = 256;
    localparam int dmem_aw = $clog2(dmem_depth);

    // instruction field positions
    localparam int op_msb = 31;
    localparam int rs_lsb = 21;
    localparam int rt_lsb = 16;
    localparam int rd_lsb = 11;
    localparam int imm_w = 16;

    typedef enum logic [5:0] {
        op_rtype = 6'h00,
        op_j     = 6'h02,
        op_beq   = 6'h04,
        op_bne   = 6'h05,
        op_addi  = 6'h08,
        op_lw    = 6'h23,
        op_sw    = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        fn_add = 6'h20,
        fn_sub = 6'h22,
        fn_and = 6'h24,
        fn_or  = 6'h25,
        fn_slt = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt
    } alu_op_e;

    // operand source in execute
    typedef enum logic [1:0] {
        fwd_none,
        fwd_mem,
        fwd_wb
    } fwd_sel_e;

endpackage

`default_nettype wire

// File: register_file.sv
`timescale 1ns/1ns
`default_nettype none

module register_file (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [mips_pkg::reg_addr_w-1:0] rs_addr,
    input  logic [mips_pkg::reg_addr_w-1:0] rt_addr,
    input  logic                            wr_en,
    input  logic [mips_pkg::reg_addr_w-1:0] wr_addr,
    input  logic [mips_pkg::word_w-1:0]     wr_data,
    output logic [mips_pkg::word_w-1:0]     rs_data,
    output logic [mips_pkg::word_w-1:0]     rt_data
);
    import mips_pkg::*;

    logic [word_w-1:0] regs [2**reg_addr_w];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**reg_addr_w; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // r0 reads zero, a write in flight is seen by the same-cycle read
    assign rs_data = (rs_addr == '0) ? '0 :
                     (wr_en && wr_addr == rs_addr) ? wr_data : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 :
                     (wr_en && wr_addr == rt_addr) ? wr_data : regs[rt_addr];

endmodule

`default_nettype wire

// File: fetch_stage.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_stage (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        stall,
    input  logic                        redirect,
    input  logic [mips_pkg::pc_w-1:0]   redirect_pc,
    input  logic [mips_pkg::word_w-1:0] imem_data,
    output logic [mips_pkg::pc_w-1:0]   imem_addr,
    output logic [mips_pkg::word_w-1:0] if_instr,
    output logic [mips_pkg::pc_w-1:0]   if_pc4,
    output logic                        if_valid
);
    import mips_pkg::*;

    logic [pc_w-1:0] pc_plus4;

    assign pc_plus4 = imem_addr + pc_w'(4);

    // pc holds on stall, redirect wins over sequential fetch
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            imem_addr <= '0;
        end else if (!stall) begin
            imem_addr <= redirect ? redirect_pc : pc_plus4;
        end
    end

    // the slot fetched alongside a redirect is flushed
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            if_valid <= 1'b0;
        end else if (!stall) begin
            if_valid <= !redirect;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if_instr <= imem_data;
            if_pc4   <= pc_plus4;
        end
    end

endmodule

`default_nettype wire

// File: decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            stall,
    input  logic [mips_pkg::word_w-1:0]     if_instr,
    input  logic [mips_pkg::pc_w-1:0]       if_pc4,
    input  logic                            if_valid,
    input  logic [mips_pkg::word_w-1:0]     rs_data,
    input  logic [mips_pkg::word_w-1:0]     rt_data,
    output logic [mips_pkg::reg_addr_w-1:0] rs_addr,
    output logic [mips_pkg::reg_addr_w-1:0] rt_addr,
    output logic                            id_uses_rs,
    output logic                            id_uses_rt,
    output logic                            id_branch,
    output logic                            redirect,
    output logic [mips_pkg::pc_w-1:0]       redirect_pc,
    output logic                            ex_valid,
    output logic [mips_pkg::word_w-1:0]     ex_a,
    output logic [mips_pkg::word_w-1:0]     ex_b,
    output logic [mips_pkg::word_w-1:0]     ex_store,
    output logic [mips_pkg::reg_addr_w-1:0] ex_rs,
    output logic [mips_pkg::reg_addr_w-1:0] ex_rt,
    output mips_pkg::alu_op_e               ex_alu_op,
    output logic                            ex_mem_rd,
    output logic                            ex_mem_wr,
    output logic                            ex_wb_en,
    output logic [mips_pkg::reg_addr_w-1:0] ex_dst
);
    import mips_pkg::*;

    opcode_e               opcode;
    funct_e                funct;
    alu_op_e               alu_op;
    logic [reg_addr_w-1:0] rd_addr;
    logic [word_w-1:0]     imm_ext;
    logic                  is_rtype;
    logic                  is_imm;
    logic                  is_beq;
    logic                  is_bne;
    logic                  is_j;
    logic                  mem_rd;
    logic                  mem_wr;
    logic                  operands_eq;

    assign opcode  = opcode_e'(if_instr[op_msb -: $bits(opcode_e)]);
    assign funct   = funct_e'(if_instr[$bits(funct_e)-1:0]);
    assign rs_addr = if_instr[rs_lsb +: reg_addr_w];
    assign rt_addr = if_instr[rt_lsb +: reg_addr_w];
    assign rd_addr = if_instr[rd_lsb +: reg_addr_w];
    assign imm_ext = {{(word_w - imm_w){if_instr[imm_w-1]}}, if_instr[imm_w-1:0]};

    assign is_rtype = opcode == op_rtype;
    assign is_beq   = opcode == op_beq;
    assign is_bne   = opcode == op_bne;
    assign is_j     = opcode == op_j;
    assign mem_rd   = opcode == op_lw;
    assign mem_wr   = opcode == op_sw;
    assign is_imm   = opcode == op_addi || mem_rd || mem_wr;

    always_comb begin
        alu_op = alu_add;
        if (is_rtype) begin
            case (funct)
                fn_sub:  alu_op = alu_sub;
                fn_and:  alu_op = alu_and;
                fn_or:   alu_op = alu_or;
                fn_slt:  alu_op = alu_slt;
                default: alu_op = alu_add;
            endcase
        end
    end

    assign id_uses_rs = if_valid && (is_rtype || is_imm || is_beq || is_bne);
    assign id_uses_rt = if_valid && (is_rtype || mem_wr || is_beq || is_bne);
    assign id_branch  = if_valid && (is_beq || is_bne);

    // branch resolves here, no delay slot
    assign operands_eq = rs_data == rt_data;
    assign redirect    = if_valid && (is_j || (is_beq && operands_eq) ||
                                      (is_bne && !operands_eq));
    // jump keeps the top pc bits and the 26-bit index
    assign redirect_pc = is_j ? {if_pc4[pc_w-1 -: 4], if_instr[25:0], 2'b00} :
                                if_pc4 + {imm_ext[pc_w-3:0], 2'b00};

    // bubble on stall
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid  <= 1'b0;
            ex_mem_rd <= 1'b0;
            ex_mem_wr <= 1'b0;
            ex_wb_en  <= 1'b0;
        end else begin
            ex_valid  <= if_valid && !stall;
            ex_mem_rd <= mem_rd;
            ex_mem_wr <= mem_wr;
            ex_wb_en  <= is_rtype || opcode == op_addi || mem_rd;
        end
    end

    // source indices are zero when not read, so they never match a forward
    always_ff @(posedge clk) begin
        ex_a      <= rs_data;
        ex_b      <= is_imm ? imm_ext : rt_data;
        ex_store  <= rt_data;
        ex_rs     <= id_uses_rs ? rs_addr : '0;
        ex_rt     <= (is_rtype || mem_wr) ? rt_addr : '0;
        ex_alu_op <= alu_op;
        ex_dst    <= is_rtype ? rd_addr : rt_addr;
    end

endmodule

`default_nettype wire

// File: execute_stage.sv
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            ex_valid,
    input  logic [mips_pkg::word_w-1:0]     ex_a,
    input  logic [mips_pkg::word_w-1:0]     ex_b,
    input  logic [mips_pkg::word_w-1:0]     ex_store,
    input  logic [mips_pkg::reg_addr_w-1:0] ex_rs,
    input  logic [mips_pkg::reg_addr_w-1:0] ex_rt,
    input  mips_pkg::alu_op_e               ex_alu_op,
    input  logic                            ex_mem_rd,
    input  logic                            ex_mem_wr,
    input  logic                            ex_wb_en,
    input  logic [mips_pkg::reg_addr_w-1:0] ex_dst,
    input  mips_pkg::fwd_sel_e              fwd_a,
    input  mips_pkg::fwd_sel_e              fwd_b,
    input  mips_pkg::fwd_sel_e              fwd_store,
    input  logic [mips_pkg::word_w-1:0]     wb_data,
    output logic                            mem_valid,
    output logic [mips_pkg::word_w-1:0]     mem_alu,
    output logic [mips_pkg::word_w-1:0]     mem_store,
    output logic                            mem_rd,
    output logic                            mem_wr,
    output logic                            mem_wb_en,
    output logic [mips_pkg::reg_addr_w-1:0] mem_dst
);
    import mips_pkg::*;

    logic [word_w-1:0] op_a;
    logic [word_w-1:0] op_b_reg;
    logic [word_w-1:0] op_b;
    logic [word_w-1:0] store_val;
    logic [word_w-1:0] alu_y;

    function automatic logic [word_w-1:0] pick(
        input fwd_sel_e          sel,
        input logic [word_w-1:0] reg_val,
        input logic [word_w-1:0] mem_val,
        input logic [word_w-1:0] wb_val
    );
        case (sel)
            fwd_mem: return mem_val;
            fwd_wb:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign op_a      = pick(fwd_a, ex_a, mem_alu, wb_data);
    assign op_b_reg  = pick(fwd_b, ex_b, mem_alu, wb_data);
    assign store_val = pick(fwd_store, ex_store, mem_alu, wb_data);

    // address offset for lw/sw; addi has no rt source so fwd_b stays none
    assign op_b = (ex_mem_rd || ex_mem_wr) ? ex_b : op_b_reg;

    always_comb begin
        case (ex_alu_op)
            alu_sub: alu_y = op_a - op_b;
            alu_and: alu_y = op_a & op_b;
            alu_or:  alu_y = op_a | op_b;
            alu_slt: alu_y = {{(word_w - 1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default: alu_y = op_a + op_b;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_valid <= 1'b0;
            mem_rd    <= 1'b0;
            mem_wr    <= 1'b0;
            mem_wb_en <= 1'b0;
        end else begin
            mem_valid <= ex_valid;
            mem_rd    <= ex_mem_rd;
            mem_wr    <= ex_mem_wr;
            mem_wb_en <= ex_wb_en;
        end
    end

    always_ff @(posedge clk) begin
        mem_alu   <= alu_y;
        mem_store <= store_val;
        mem_dst   <= ex_dst;
    end

endmodule

`default_nettype wire

// File: memory_stage.sv
`timescale 1ns/1ns
`default_nettype none

module memory_stage (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            mem_valid,
    input  logic [mips_pkg::word_w-1:0]     mem_alu,
    input  logic [mips_pkg::word_w-1:0]     mem_store,
    input  logic                            mem_rd,
    input  logic                            mem_wr,
    input  logic                            mem_wb_en,
    input  logic [mips_pkg::reg_addr_w-1:0] mem_dst,
    output logic                            wb_valid,
    output logic [mips_pkg::reg_addr_w-1:0] wb_reg,
    output logic [mips_pkg::word_w-1:0]     wb_data
);
    import mips_pkg::*;

    logic [word_w-1:0]  dmem [dmem_depth];
    logic [dmem_aw-1:0] word_addr;
    logic [word_w-1:0]  wb_alu;
    logic [word_w-1:0]  wb_load;
    logic               wb_is_load;

    // byte address, word granular
    assign word_addr = mem_alu[dmem_aw+1:2];

    always_ff @(posedge clk) begin
        if (mem_valid && mem_wr) begin
            dmem[word_addr] <= mem_store;
        end
    end

    // writes to r0 never retire
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid   <= 1'b0;
            wb_is_load <= 1'b0;
        end else begin
            wb_valid   <= mem_valid && mem_wb_en && mem_dst != '0;
            wb_is_load <= mem_rd;
        end
    end

    always_ff @(posedge clk) begin
        wb_reg  <= mem_dst;
        wb_alu  <= mem_alu;
        wb_load <= dmem[word_addr];
    end

    assign wb_data = wb_is_load ? wb_load : wb_alu;

endmodule

`default_nettype wire

// File: hazard_unit.sv
`timescale 1ns/1ns
`default_nettype none

module hazard_unit (
    input  logic                            id_uses_rs,
    input  logic                            id_uses_rt,
    input  logic                            id_branch,
    input  logic [mips_pkg::reg_addr_w-1:0] rs_addr,
    input  logic [mips_pkg::reg_addr_w-1:0] rt_addr,
    input  logic                            ex_valid,
    input  logic [mips_pkg::reg_addr_w-1:0] ex_rs,
    input  logic [mips_pkg::reg_addr_w-1:0] ex_rt,
    input  logic [mips_pkg::reg_addr_w-1:0] ex_dst,
    input  logic                            ex_wb_en,
    input  logic                            ex_mem_rd,
    input  logic                            mem_valid,
    input  logic [mips_pkg::reg_addr_w-1:0] mem_dst,
    input  logic                            mem_wb_en,
    input  logic                            wb_valid,
    input  logic [mips_pkg::reg_addr_w-1:0] wb_reg,
    output logic                            stall,
    output mips_pkg::fwd_sel_e              fwd_a,
    output mips_pkg::fwd_sel_e              fwd_b,
    output mips_pkg::fwd_sel_e              fwd_store
);
    import mips_pkg::*;

    logic ex_writes;
    logic mem_writes;
    logic load_use;
    logic branch_wait;

    assign ex_writes  = ex_valid && ex_wb_en && ex_dst != '0;
    assign mem_writes = mem_valid && mem_wb_en && mem_dst != '0;

    // load result only exists after the memory stage
    assign load_use = ex_valid && ex_mem_rd && ex_dst != '0 &&
                      ((id_uses_rs && rs_addr == ex_dst) || (id_uses_rt && rt_addr == ex_dst));

    // branch compares in decode, so wait until the writer reaches writeback
    assign branch_wait = id_branch &&
                         ((ex_writes && (ex_dst == rs_addr || ex_dst == rt_addr)) ||
                          (mem_writes && (mem_dst == rs_addr || mem_dst == rt_addr)));

    assign stall = load_use || branch_wait;

    // memory stage is younger, so it wins
    assign fwd_a = (mem_writes && mem_dst == ex_rs) ? fwd_mem :
                   (wb_valid && wb_reg == ex_rs) ? fwd_wb : fwd_none;
    assign fwd_b = (mem_writes && mem_dst == ex_rt) ? fwd_mem :
                   (wb_valid && wb_reg == ex_rt) ? fwd_wb : fwd_none;
    assign fwd_store = fwd_b;

endmodule

`default_nettype wire

// File: mips_core.sv
`timescale 1ns/1ns
`default_nettype none

module mips_core (
    input  logic                            clk_raw,
    input  logic                            rst_n,
    input  logic [mips_pkg::word_w-1:0]     imem_data,
    output logic [mips_pkg::pc_w-1:0]       imem_addr,
    output logic                            wb_valid,
    output logic [mips_pkg::reg_addr_w-1:0] wb_reg,
    output logic [mips_pkg::word_w-1:0]     wb_data
);
    import mips_pkg::*;

    // fetch and decode
    logic                  stall;
    logic                  redirect;
    logic [pc_w-1:0]       redirect_pc;
    logic [word_w-1:0]     if_instr;
    logic [pc_w-1:0]       if_pc4;
    logic                  if_valid;
    logic [reg_addr_w-1:0] rs_addr;
    logic [reg_addr_w-1:0] rt_addr;
    logic [word_w-1:0]     rs_data;
    logic [word_w-1:0]     rt_data;
    logic                  id_uses_rs;
    logic                  id_uses_rt;
    logic                  id_branch;

    // decode to execute
    logic                  ex_valid;
    logic [word_w-1:0]     ex_a;
    logic [word_w-1:0]     ex_b;
    logic [word_w-1:0]     ex_store;
    logic [reg_addr_w-1:0] ex_rs;
    logic [reg_addr_w-1:0] ex_rt;
    alu_op_e               ex_alu_op;
    logic                  ex_mem_rd;
    logic                  ex_mem_wr;
    logic                  ex_wb_en;
    logic [reg_addr_w-1:0] ex_dst;
    fwd_sel_e              fwd_a;
    fwd_sel_e              fwd_b;
    fwd_sel_e              fwd_store;

    // execute to memory
    logic                  mem_valid;
    logic [word_w-1:0]     mem_alu;
    logic [word_w-1:0]     mem_store;
    logic                  mem_rd;
    logic                  mem_wr;
    logic                  mem_wb_en;
    logic [reg_addr_w-1:0] mem_dst;

    fetch_stage u_fetch (.clk(clk_raw), .*);

    decode_stage u_decode (.clk(clk_raw), .*);

    register_file u_regs (
        .clk     (clk_raw),
        .rst_n   (rst_n),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .wr_en   (wb_valid),
        .wr_addr (wb_reg),
        .wr_data (wb_data),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    execute_stage u_execute (.clk(clk_raw), .*);

    memory_stage u_memory (.clk(clk_raw), .*);

    hazard_unit u_hazard (.*);

endmodule

`default_nettype wire

// File: mips_core_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module mips_core_asserts (
    input logic                            clk_raw,
    input logic                            rst_n,
    input logic [mips_pkg::pc_w-1:0]       imem_addr,
    input logic                            wb_valid,
    input logic [mips_pkg::reg_addr_w-1:0] wb_reg
);

    reset_quiet: assert property (@(posedge clk_raw) !rst_n |-> !wb_valid)
        else $error("wb_valid high while in reset");

    // first cycle out of reset is still empty
    release_quiet: assert property (@(posedge clk_raw) $rose(rst_n) |=> !wb_valid)
        else $error("wb_valid high on the first cycle after reset");

    no_r0_retire: assert property (@(posedge clk_raw) disable iff (!rst_n)
                                   wb_valid |-> wb_reg != '0)
        else $error("retirement reported for register 0");

    pc_aligned: assert property (@(posedge clk_raw) imem_addr[1:0] == 2'b00)
        else $error("instruction address not word aligned");

endmodule

bind mips_core mips_core_asserts u_asserts (
    .clk_raw   (clk_raw),
    .rst_n     (rst_n),
    .imem_addr (imem_addr),
    .wb_valid  (wb_valid),
    .wb_reg    (wb_reg)
);

`default_nettype wire

// File: mips_core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module mips_core_tb;
    import mips_pkg::*;

    logic                  clk;
    logic                  rst_n;
    logic [word_w-1:0]     imem_data;
    logic [pc_w-1:0]       imem_addr;
    logic                  wb_valid;
    logic [reg_addr_w-1:0] wb_reg;
    logic [word_w-1:0]     wb_data;

    // program image of at most 32 words
    logic [word_w-1:0]     prog [32];
    string                 tags [32];
    int                    prog_len = 0;
    int                    seed;
    int                    cycles = 0;
    int                    cycle_limit;

    logic [reg_addr_w-1:0] exp_reg [$];
    logic [word_w-1:0]     exp_val [$];
    string                 exp_tag [$];

    mips_core DUT (
        .clk_raw   (clk),
        .rst_n     (rst_n),
        .imem_data (imem_data),
        .imem_addr (imem_addr),
        .wb_valid  (wb_valid),
        .wb_reg    (wb_reg),
        .wb_data   (wb_data)
    );

    // instruction memory answers in the same cycle
    assign imem_data = (imem_addr < pc_w'(prog_len * 4)) ? prog[imem_addr[6:2]] : '0;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    function automatic logic [word_w-1:0] encode_r(funct_e fn, int rd, int rs, int rt);
        return {op_rtype, reg_addr_w'(rs), reg_addr_w'(rt), reg_addr_w'(rd), 5'd0, fn};
    endfunction

    function automatic logic [word_w-1:0] encode_i(opcode_e op, int rt, int rs,
                                                   logic [imm_w-1:0] imm);
        return {op, reg_addr_w'(rs), reg_addr_w'(rt), imm};
    endfunction

    function automatic logic [word_w-1:0] encode_j(int target);
        return {op_j, 26'(target)};
    endfunction

    function automatic logic [imm_w-1:0] random_imm();
        return imm_w'($random(seed));
    endfunction

    task automatic append_instr(input logic [word_w-1:0] instr, input string tag);
        prog[prog_len[4:0]] = instr;
        tags[prog_len[4:0]] = tag;
        prog_len++;
    endtask

    task automatic build_program();
        logic [imm_w-1:0] off_a;
        logic [imm_w-1:0] off_b;
        off_a = imm_w'({8'($random(seed)), 2'b00});
        off_b = imm_w'({8'($random(seed)), 2'b00});
        append_instr(encode_i(op_addi, 1, 0, random_imm()), "dependency chain");
        append_instr(encode_i(op_addi, 2, 1, random_imm()), "dependency chain");
        append_instr(encode_r(fn_add, 3, 1, 2), "dependency chain");
        append_instr(encode_r(fn_sub, 4, 3, 1), "dependency chain");
        append_instr(encode_r(fn_and, 5, 4, 3), "dependency chain");
        append_instr(encode_r(fn_or, 6, 5, 2), "dependency chain");
        append_instr(encode_r(fn_slt, 7, 4, 3), "dependency chain");
        // write to r0 that must neither retire nor forward
        append_instr(encode_i(op_addi, 0, 7, random_imm()), "register zero");
        append_instr(encode_i(op_sw, 6, 0, off_a), "load use");
        append_instr(encode_i(op_lw, 8, 0, off_a), "load use");
        append_instr(encode_r(fn_add, 9, 8, 1), "load use");
        // taken beq right after its operand is written
        append_instr(encode_i(op_beq, 9, 9, 16'd1), "branches");
        append_instr(encode_i(op_addi, 10, 0, random_imm()), "branches");
        append_instr(encode_i(op_addi, 11, 9, random_imm() | 16'd1), "branches");
        append_instr(encode_i(op_beq, 9, 11, 16'd1), "branches");
        append_instr(encode_i(op_addi, 12, 0, random_imm() | 16'd1), "branches");
        append_instr(encode_i(op_bne, 0, 12, 16'd1), "branches");
        append_instr(encode_i(op_addi, 13, 0, random_imm()), "branches");
        append_instr(encode_i(op_bne, 11, 11, 16'd1), "branches");
        append_instr(encode_j(21), "jumps");
        append_instr(encode_i(op_addi, 14, 0, random_imm()), "jumps");
        append_instr(encode_i(op_sw, 12, 0, off_b), "jumps");
        append_instr(encode_i(op_lw, 15, 0, off_b), "jumps");
        append_instr(encode_r(fn_sub, 16, 15, 11), "jumps");
        append_instr(encode_j(24), "jumps");
    endtask

    // sequential ISA model stepping one instruction at a time
    task automatic run_golden();
        logic [word_w-1:0]     regs [2**reg_addr_w];
        logic [word_w-1:0]     mem [dmem_depth];
        logic [word_w-1:0]     instr;
        logic [word_w-1:0]     imm;
        logic [word_w-1:0]     a;
        logic [word_w-1:0]     b;
        logic [word_w-1:0]     addr;
        logic [word_w-1:0]     res;
        logic [reg_addr_w-1:0] dst;
        logic                  writes;
        logic                  done;
        int                    pc;
        int                    next_pc;
        int                    steps;
        for (int i = 0; i < 2**reg_addr_w; i++) begin
            regs[i] = '0;
        end
        pc = 0;
        steps = 0;
        done = 1'b0;
        while (!done && steps < 100) begin
            instr = prog[pc[4:0]];
            a = regs[instr[rs_lsb +: reg_addr_w]];
            b = regs[instr[rt_lsb +: reg_addr_w]];
            imm = {{(word_w - imm_w){instr[imm_w-1]}}, instr[imm_w-1:0]};
            addr = a + imm;
            dst = instr[rt_lsb +: reg_addr_w];
            res = '0;
            writes = 1'b0;
            next_pc = pc + 1;
            case (opcode_e'(instr[op_msb -: 6]))
                op_rtype: begin
                    dst = instr[rd_lsb +: reg_addr_w];
                    writes = 1'b1;
                    case (funct_e'(instr[5:0]))
                        fn_sub:  res = a - b;
                        fn_and:  res = a & b;
                        fn_or:   res = a | b;
                        fn_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: res = a + b;
                    endcase
                end
                op_addi: begin
                    res = addr;
                    writes = 1'b1;
                end
                op_lw: begin
                    res = mem[addr[dmem_aw+1:2]];
                    writes = 1'b1;
                end
                op_sw: mem[addr[dmem_aw+1:2]] = b;
                op_beq: next_pc = (a == b) ? pc + 1 + int'($signed(imm)) : pc + 1;
                op_bne: next_pc = (a != b) ? pc + 1 + int'($signed(imm)) : pc + 1;
                op_j: begin
                    next_pc = int'(instr[25:0]);
                    done = next_pc == pc;
                end
                default: next_pc = pc + 1;
            endcase
            if (writes && dst != '0) begin
                regs[dst] = res;
                exp_reg.push_back(dst);
                exp_val.push_back(res);
                exp_tag.push_back(tags[pc[4:0]]);
            end
            pc = next_pc;
            steps++;
        end
        if (!done) begin
            stop_with_failure("golden model never reached the closing jump");
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            stop_with_failure($sformatf("timeout after %0d cycles, %0d retirements missing",
                                        cycles, exp_reg.size()));
        end
    end

    // outputs are stable at the falling edge
    always @(negedge clk) begin : check_retire
        logic [reg_addr_w-1:0] want_reg;
        logic [word_w-1:0]     want_val;
        string                 want_tag;
        if (wb_valid) begin
            if (exp_reg.size() == 0) begin
                stop_with_failure($sformatf("unexpected retirement of r%0d after the last one",
                                            wb_reg));
            end else begin
                want_reg = exp_reg.pop_front();
                want_val = exp_val.pop_front();
                want_tag = exp_tag.pop_front();
                assert (wb_reg == want_reg && wb_data == want_val) else begin
                    stop_with_failure($sformatf("FAILED %s: expected r%0d=%08h, actual r%0d=%08h",
                                                want_tag, want_reg, want_val, wb_reg, wb_data));
                end
            end
        end
    end

    initial begin
        rst_n = 1'b1;
        seed = 55007;
        build_program();
        run_golden();
        cycle_limit = 16 + 3 * prog_len + 50;
        #1 rst_n = 1'b0;
        repeat (16) @(posedge clk);
        #1 rst_n = 1'b1;
        while (exp_reg.size() != 0) begin
            @(posedge clk);
        end
        // a stray retirement while the closing jump spins still shows up here
        repeat (8) @(posedge clk);
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: mips_core.f
mips_pkg.sv
register_file.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
hazard_unit.sv
mips_core.sv
mips_core_asserts.sv
mips_core_tb.sv

// File: Makefile
TOP = mips_core_tb

all: run

run:
	verilator --binary --timing --assert -f mips_core.f --top-module $(TOP) -Mdir obj_dir -o sim
	./obj_dir/sim

lint:
	verilator --lint-only -Wall --timing --assert -f mips_core.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
